//--- Makefile
TOP  := tb_lsu_top
SRCS := $(shell cat src.f)

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --assert --timing --timescale 1ns/100ps -j 0 --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- src.f
src/lsu_pkg.sv
src/lsu_data_align.sv
src/lsu_unit.sv
src/axi_lite_sram.sv
src/lsu_top.sv
testbench/tb_lsu_top.sv

//--- src/axi_lite_sram.sv
`timescale 1ns/100ps

module axi_lite_sram #(
  parameter int mem_words   = 1024,
  parameter int ready_delay = 2
) (
  input  logic                 clock,
  input  logic                 reset,

  input  logic                 ar_valid,
  output logic                 ar_ready,
  input  lsu_pkg::axi_ar_t     ar,

  output logic                 r_valid,
  input  logic                 r_ready,
  output lsu_pkg::axi_r_t      r,

  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  lsu_pkg::axi_aw_t     aw,

  input  logic                 w_valid,
  output logic                 w_ready,
  input  lsu_pkg::axi_w_t      w,

  output logic                 b_valid,
  input  logic                 b_ready,
  output lsu_pkg::axi_b_t      b
);

  localparam int index_width = $clog2(mem_words);
  localparam logic [2:0] delay_max = 3'(ready_delay);

  logic [lsu_pkg::data_width-1:0] mem [mem_words];

  logic [2:0]                     rd_count;
  logic [2:0]                     wr_count;
  logic                           rd_pending;
  logic [index_width-1:0]         rd_index;
  logic [lsu_pkg::data_width-1:0] r_data_q;
  logic                           aw_got;
  logic                           w_got;
  logic [index_width-1:0]         wr_index;
  logic [lsu_pkg::data_width-1:0] wr_data;
  logic [lsu_pkg::strb_width-1:0] wr_strb;
  logic                           rd_wait;
  logic                           wr_wait;
  logic                           wr_commit;

  assign r = '{data: r_data_q, resp: lsu_pkg::resp_okay};
  assign b = '{resp: lsu_pkg::resp_okay};

  // Read side counts while an address waits or while data is due
  assign rd_wait = rd_pending ? !r_valid : (ar_valid & !ar_ready);

  // Write side counts while either aw or w is still outstanding
  assign wr_wait = !b_valid &&
                   ((aw_valid && !aw_got && !aw_ready) || (w_valid && !w_got && !w_ready));

  assign wr_commit = aw_got & w_got & !b_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready   <= 1'b0;
      r_valid    <= 1'b0;
      rd_pending <= 1'b0;
      rd_count   <= 3'd0;
    end else begin
      ar_ready <= 1'b0;
      if (rd_wait) begin
        if (rd_count == delay_max) begin
          rd_count <= 3'd0;
          if (rd_pending) begin
            r_valid <= 1'b1;
          end else begin
            ar_ready <= 1'b1;
          end
        end else begin
          rd_count <= rd_count + 3'd1;
        end
      end
      if (ar_valid && ar_ready) begin
        rd_pending <= 1'b1;
      end
      if (r_valid && r_ready) begin
        r_valid    <= 1'b0;
        rd_pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      b_valid  <= 1'b0;
      wr_count <= 3'd0;
    end else begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      if (wr_wait) begin
        if (wr_count == delay_max) begin
          wr_count <= 3'd0;
          aw_ready <= aw_valid & !aw_got & !aw_ready;
          w_ready  <= w_valid & !w_got & !w_ready;
        end else begin
          wr_count <= wr_count + 3'd1;
        end
      end
      if (aw_valid && aw_ready) begin
        aw_got <= 1'b1;
      end
      if (w_valid && w_ready) begin
        w_got <= 1'b1;
      end
      if (wr_commit) begin
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
        b_valid <= 1'b1;
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // Storage and captured payloads
  always_ff @(posedge clock) begin
    if (ar_valid && ar_ready) begin
      rd_index <= ar.addr[index_width+1:2];
    end
    if (rd_pending && rd_wait && rd_count == delay_max) begin
      r_data_q <= mem[rd_index];
    end
    if (aw_valid && aw_ready) begin
      wr_index <= aw.addr[index_width+1:2];
    end
    if (w_valid && w_ready) begin
      wr_data <= w.data;
      wr_strb <= w.strb;
    end
    if (wr_commit) begin
      for (int i = 0; i < lsu_pkg::strb_width; i++) begin
        if (wr_strb[i]) begin
          mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- src/lsu_data_align.sv
`timescale 1ns/100ps

module lsu_data_align (
  input  lsu_pkg::access_size_e                size,
  input  logic                                 sext,
  input  logic [1:0]                           offset,
  input  logic [lsu_pkg::data_width-1:0]       wsrc,
  input  logic [lsu_pkg::data_width-1:0]       rdata_raw,
  output logic [lsu_pkg::data_width-1:0]       wdata,
  output logic [lsu_pkg::strb_width-1:0]       wstrb,
  output logic [lsu_pkg::data_width-1:0]       rdata_ext
);

  logic [4:0]                     shamt;
  logic [lsu_pkg::data_width-1:0] rdata_shifted;

  // Byte lane offset in bits
  assign shamt = {offset, 3'b000};

  always_comb begin
    if (size == lsu_pkg::size_word) begin
      wdata = wsrc;
    end else begin
      wdata = wsrc << shamt;
    end
  end

  always_comb begin
    case (size)
      lsu_pkg::size_byte: wstrb = 4'b0001 << offset;
      lsu_pkg::size_half: wstrb = 4'b0011 << offset;
      default:            wstrb = 4'b1111;
    endcase
  end

  // Bring the addressed byte or half down to bit 0
  always_comb begin
    if (size == lsu_pkg::size_word) begin
      rdata_shifted = rdata_raw;
    end else begin
      rdata_shifted = rdata_raw >> shamt;
    end
  end

  always_comb begin
    case (size)
      lsu_pkg::size_byte: begin
        rdata_ext = {{24{sext & rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      lsu_pkg::size_half: begin
        rdata_ext = {{16{sext & rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: begin
        rdata_ext = rdata_shifted;
      end
    endcase
  end

endmodule

//--- src/lsu_pkg.sv
package lsu_pkg;

  parameter int addr_width = 32;
  parameter int data_width = 32;
  parameter int strb_width = data_width / 8;

  // AXI response code, the memory slave always answers OKAY
  parameter logic [1:0] resp_okay = 2'b00;

  // Encoded the same way as the AXI size field
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  // Request from the execute stage
  typedef struct packed {
    logic                  ren;
    logic                  wen;
    access_size_e          size;
    logic                  sext;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wsrc;
  } mem_req_t;

  // Bundle handed on to writeback
  typedef struct packed {
    logic [addr_width-1:0] pc;
    logic [data_width-1:0] data;
  } stage_result_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [2:0]            size;
  } axi_ar_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [2:0]            size;
  } axi_aw_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [1:0]            resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- src/lsu_top.sv
`timescale 1ns/100ps

module lsu_top #(
  parameter int mem_words   = 1024,
  parameter int ready_delay = 2
) (
  input  logic                             clock,
  input  logic                             reset,
  input  lsu_pkg::mem_req_t                req,
  input  logic [lsu_pkg::addr_width-1:0]   req_pc,
  input  logic [lsu_pkg::data_width-1:0]   pass_data,
  input  logic                             flush,
  output lsu_pkg::stage_result_t           result,
  output logic                             busy
);

  logic              ar_valid;
  logic              ar_ready;
  lsu_pkg::axi_ar_t  ar;
  logic              r_valid;
  logic              r_ready;
  lsu_pkg::axi_r_t   r;
  logic              aw_valid;
  logic              aw_ready;
  lsu_pkg::axi_aw_t  aw;
  logic              w_valid;
  logic              w_ready;
  lsu_pkg::axi_w_t   w;
  logic              b_valid;
  logic              b_ready;
  lsu_pkg::axi_b_t   b;

  lsu_unit lsu_i (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_pc    (req_pc),
    .pass_data (pass_data),
    .flush     (flush),
    .result    (result),
    .busy      (busy),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r         (r),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .aw        (aw),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w         (w),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b         (b)
  );

  axi_lite_sram #(
    .mem_words   (mem_words),
    .ready_delay (ready_delay)
  ) sram_i (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw       (aw),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w        (w),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b)
  );

endmodule

//--- src/lsu_unit.sv
`timescale 1ns/100ps

module lsu_unit (
  input  logic                             clock,
  input  logic                             reset,

  input  lsu_pkg::mem_req_t                req,
  input  logic [lsu_pkg::addr_width-1:0]   req_pc,
  input  logic [lsu_pkg::data_width-1:0]   pass_data,
  input  logic                             flush,
  output lsu_pkg::stage_result_t           result,
  output logic                             busy,

  output logic                             ar_valid,
  input  logic                             ar_ready,
  output lsu_pkg::axi_ar_t                 ar,

  input  logic                             r_valid,
  output logic                             r_ready,
  input  lsu_pkg::axi_r_t                  r,

  output logic                             aw_valid,
  input  logic                             aw_ready,
  output lsu_pkg::axi_aw_t                 aw,

  output logic                             w_valid,
  input  logic                             w_ready,
  output lsu_pkg::axi_w_t                  w,

  input  logic                             b_valid,
  output logic                             b_ready,
  input  lsu_pkg::axi_b_t                  b
);

  lsu_pkg::mem_req_t              req_q;
  logic                           launch;
  logic                           ar_done;
  logic                           r_done;
  logic                           aw_done;
  logic                           w_done;
  logic                           b_done;
  logic [lsu_pkg::data_width-1:0] wdata;
  logic [lsu_pkg::strb_width-1:0] wstrb;
  logic [lsu_pkg::data_width-1:0] rdata_ext;

  lsu_data_align align_i (
    .size      (req_q.size),
    .sext      (req_q.sext),
    .offset    (req_q.addr[1:0]),
    .wsrc      (req_q.wsrc),
    .rdata_raw (r.data),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .rdata_ext (rdata_ext)
  );

  // Address and size come straight from the held request
  assign ar = '{addr: req_q.addr, size: {1'b0, req_q.size}};
  assign aw = '{addr: req_q.addr, size: {1'b0, req_q.size}};
  assign w  = '{data: wdata, strb: wstrb};

  // Handshake on each channel
  assign ar_done = ar_valid & ar_ready;
  assign r_done  = r_valid & r_ready;
  assign aw_done = aw_valid & aw_ready;
  assign w_done  = w_valid & w_ready;
  assign b_done  = b_valid & b_ready;

  // Request and result payload, loaded whenever the stage is free
  always_ff @(posedge clock) begin
    if (!busy) begin
      req_q       <= req;
      result.pc   <= req_pc;
      result.data <= pass_data;
    end else if (r_done) begin
      result.data <= rdata_ext;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      launch   <= 1'b0;
      ar_valid <= 1'b0;
      r_ready  <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      b_ready  <= 1'b0;
    end else if (!busy) begin
      busy   <= req.ren | req.wen;
      launch <= req.ren | req.wen;
    end else begin
      launch <= 1'b0;

      // First busy cycle: a flush here drops the request untouched
      if (launch) begin
        if (flush) begin
          busy <= 1'b0;
        end else begin
          ar_valid <= req_q.ren;
          // Address and data go out together
          aw_valid <= req_q.wen;
          w_valid  <= req_q.wen;
        end
      end

      if (ar_done) begin
        ar_valid <= 1'b0;
        r_ready  <= 1'b1;
      end

      if (r_done) begin
        r_ready <= 1'b0;
        busy    <= 1'b0;
      end

      // aw and w drop on their own, so the slave may take them in any order
      if (aw_done) begin
        aw_valid <= 1'b0;
      end

      if (w_done) begin
        w_valid <= 1'b0;
        b_ready <= 1'b1;
      end

      // Write response is taken but its code is not acted on
      if (b_done) begin
        b_ready <= 1'b0;
        busy    <= 1'b0;
      end
    end
  end

endmodule

//--- testbench/tb_lsu_top.sv
`timescale 1ns/100ps

module tb_lsu_top;

  localparam int mem_words     = 256;
  localparam int ready_delay   = 2;
  localparam int mem_bytes     = mem_words * 4;
  localparam int access_limit  = 40;
  localparam int access_budget = 320;
  localparam int no_flush      = -1;

  logic                   clock;
  logic                   reset;
  lsu_pkg::mem_req_t      req;
  logic [31:0]            req_pc;
  logic [31:0]            pass_data;
  logic                   flush;
  lsu_pkg::stage_result_t result;
  logic                   busy;

  // Byte-wide reference model of the slave memory
  logic [7:0]  model_mem [mem_bytes];
  logic [15:0] lfsr_state;
  logic [31:0] pc_counter;
  int          errors;
  int          checks;

  lsu_top #(
    .mem_words   (mem_words),
    .ready_delay (ready_delay)
  ) dut_i (
    .clock     (clock),
    .reset     (reset),
    .req       (req),
    .req_pc    (req_pc),
    .pass_data (pass_data),
    .flush     (flush),
    .result    (result),
    .busy      (busy)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Every access is bounded by access_limit cycles, plus some slack for reset
  initial begin
    #(10 * (access_budget * access_limit + 100));
    $display("Watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int count);
    logic [31:0] value;
    logic        fb;
    value = 32'd0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic logic [31:0] next_pc();
    pc_counter = pc_counter + 32'd4;
    return pc_counter;
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'ha5c3_0f96;
  endfunction

  function automatic lsu_pkg::mem_req_t make_req(input logic ren, input logic wen,
      input lsu_pkg::access_size_e size, input logic sext, input logic [31:0] addr,
      input logic [31:0] wsrc);
    lsu_pkg::mem_req_t r;
    r.ren  = ren;
    r.wen  = wen;
    r.size = size;
    r.sext = sext;
    r.addr = addr;
    r.wsrc = wsrc;
    return r;
  endfunction

  function automatic int size_bytes(input lsu_pkg::access_size_e size);
    case (size)
      lsu_pkg::size_byte: return 1;
      lsu_pkg::size_half: return 2;
      default:            return 4;
    endcase
  endfunction

  // Slave drops the low two bits and wraps at the memory depth
  function automatic int lane_index(input logic [31:0] addr, input int lane);
    logic [31:0] word_base;
    word_base = (addr & 32'hffff_fffc) % 32'(mem_bytes);
    return int'(word_base) + lane;
  endfunction

  function automatic int lane_offset(input logic [31:0] addr, input lsu_pkg::access_size_e size);
    return (size == lsu_pkg::size_word) ? 0 : int'(addr[1:0]);
  endfunction

  function automatic void model_store(input logic [31:0] addr,
      input lsu_pkg::access_size_e size, input logic [31:0] value);
    int off;
    off = lane_offset(addr, size);
    for (int k = 0; k < size_bytes(size); k++) begin
      model_mem[lane_index(addr, off + k)] = value[8*k +: 8];
    end
  endfunction

  function automatic logic [31:0] expected_load(input logic [31:0] addr,
      input lsu_pkg::access_size_e size, input logic sext);
    logic [31:0] raw;
    int          off;
    raw = 32'd0;
    off = lane_offset(addr, size);
    for (int k = 0; k < size_bytes(size); k++) begin
      raw[8*k +: 8] = model_mem[lane_index(addr, off + k)];
    end
    if (sext && size == lsu_pkg::size_byte && raw[7]) begin
      raw[31:8] = 24'hff_ffff;
    end
    if (sext && size == lsu_pkg::size_half && raw[15]) begin
      raw[31:16] = 16'hffff;
    end
    return raw;
  endfunction

  task automatic check_value(input string name, input logic [31:0] addr,
                             input logic [31:0] got, input logic [31:0] expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("ERROR %s at address 0x%h: got 0x%h, expected 0x%h", name, addr, got, expected);
    end
  endtask

  // Called on a rising edge with busy low; returns on the edge where busy is seen low again
  task automatic run_access(input lsu_pkg::mem_req_t r, input logic [31:0] pc,
                            input logic [31:0] pass, input int flush_at,
                            output logic [31:0] data, output int cycles);
    req       <= r;
    req_pc    <= pc;
    pass_data <= pass;
    @(posedge clock);
    req   <= make_req(1'b0, 1'b0, lsu_pkg::size_word, 1'b0, 32'd0, 32'd0);
    flush <= (flush_at == 0);
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      flush <= (cycles == flush_at);
    end while (busy && cycles < access_limit);
    checks++;
    assert (!busy) else begin
      errors++;
      $display("Access to address 0x%h did not finish within %0d cycles", r.addr, access_limit);
    end
    data = result.data;
    check_value("result.pc", r.addr, result.pc, pc);
  endtask

  task automatic store(input logic [31:0] addr, input lsu_pkg::access_size_e size,
                       input logic [31:0] value);
    logic [31:0] data;
    logic [31:0] pass;
    int          cycles;
    pass = ~value ^ addr;
    run_access(make_req(1'b0, 1'b1, size, 1'b0, addr, value), next_pc(), pass, no_flush,
               data, cycles);
    model_store(addr, size, value);
    // A store leaves the execute result on the writeback bus
    check_value("result.data", addr, data, pass);
  endtask

  task automatic load_check(input logic [31:0] addr, input lsu_pkg::access_size_e size,
                            input logic sext);
    logic [31:0] data;
    int          cycles;
    run_access(make_req(1'b1, 1'b0, size, sext, addr, 32'd0), next_pc(), 32'h0bad_cafe,
               no_flush, data, cycles);
    check_value("result.data", addr, data, expected_load(addr, size, sext));
  endtask

  task automatic word_round_trip();
    logic [31:0] addr;
    for (int i = 0; i < 6; i++) begin
      addr = 32'h40 + 32'(i) * 32'h24;
      store(addr, lsu_pkg::size_word, rand_bits(32));
    end
    for (int i = 0; i < 6; i++) begin
      addr = 32'h40 + 32'(i) * 32'h24;
      load_check(addr, lsu_pkg::size_word, 1'b0);
    end
  endtask

  task automatic sub_word_stores();
    logic [31:0] base;
    base = 32'h200;
    for (int off = 0; off < 4; off++) begin
      store(base, lsu_pkg::size_word, fill_pattern(base));
      store(base + 32'(off), lsu_pkg::size_byte, rand_bits(32));
      load_check(base, lsu_pkg::size_word, 1'b0);
    end
    // Halves at 0, 1 and 2 stay inside the word
    for (int off = 0; off < 3; off++) begin
      store(base, lsu_pkg::size_word, fill_pattern(base));
      store(base + 32'(off), lsu_pkg::size_half, rand_bits(32));
      load_check(base, lsu_pkg::size_word, 1'b0);
    end
  endtask

  task automatic load_extension();
    logic [31:0] base;
    store(32'h300, lsu_pkg::size_word, 32'h8fa5_ff90);
    store(32'h304, lsu_pkg::size_word, 32'h7f3c_5106);
    for (int w = 0; w < 2; w++) begin
      base = 32'h300 + 32'(w) * 32'd4;
      for (int s = 0; s < 2; s++) begin
        for (int off = 0; off < 4; off++) begin
          load_check(base + 32'(off), lsu_pkg::size_byte, s[0]);
        end
        load_check(base, lsu_pkg::size_half, s[0]);
        load_check(base + 32'd2, lsu_pkg::size_half, s[0]);
      end
    end
  endtask

  task automatic pass_through();
    logic [31:0] data;
    logic [31:0] pass;
    int          cycles;
    for (int i = 0; i < 4; i++) begin
      pass = rand_bits(32);
      run_access(make_req(1'b0, 1'b0, lsu_pkg::size_word, 1'b1, rand_bits(32), rand_bits(32)),
                 next_pc(), pass, no_flush, data, cycles);
      checks++;
      assert (cycles == 1) else begin
        errors++;
        $display("Request without ren or wen raised busy for %0d cycles", cycles - 1);
      end
      check_value("result.data", 32'd0, data, pass);
    end
    store(32'h3f0, lsu_pkg::size_half, rand_bits(32));
  endtask

  task automatic flush_handling();
    logic [31:0] addr;
    logic [31:0] data;
    int          cycles;
    addr = 32'h380;
    store(addr, lsu_pkg::size_word, fill_pattern(addr));
    run_access(make_req(1'b0, 1'b1, lsu_pkg::size_word, 1'b0, addr, 32'hbad0_bad0), next_pc(),
               32'd0, 0, data, cycles);
    checks++;
    assert (cycles == 2) else begin
      errors++;
      $display("Flushed store kept busy high for %0d cycles instead of one", cycles - 1);
    end
    load_check(addr, lsu_pkg::size_word, 1'b0);
    // Flush once the read address is out has no effect
    run_access(make_req(1'b1, 1'b0, lsu_pkg::size_word, 1'b0, addr, 32'd0), next_pc(),
               32'd0, 2, data, cycles);
    check_value("result.data", addr, data, expected_load(addr, lsu_pkg::size_word, 1'b0));
  endtask

  task automatic random_accesses();
    logic [31:0] bits;
    logic [31:0] addr;
    logic [31:0] off;
    lsu_pkg::access_size_e size;
    for (int w = 0; w < 16; w++) begin
      addr = 32'h100 + 32'(w) * 32'd4;
      store(addr, lsu_pkg::size_word, fill_pattern(addr));
    end
    for (int i = 0; i < 200; i++) begin
      bits = rand_bits(2);
      off  = rand_bits(2);
      case (bits)
        32'd0:   size = lsu_pkg::size_byte;
        32'd1:   size = lsu_pkg::size_half;
        default: size = lsu_pkg::size_word;
      endcase
      if (size == lsu_pkg::size_word) begin
        off = 32'd0;
      end else if (size == lsu_pkg::size_half && off == 32'd3) begin
        off = 32'd2;
      end
      // Upper bits alias back into the same 16-word region
      addr = (rand_bits(6) << 10) | 32'h100 | (rand_bits(4) << 2) | off;
      bits = rand_bits(1);
      if (bits[0]) begin
        store(addr, size, rand_bits(32));
      end else begin
        bits = rand_bits(1);
        load_check(addr, size, bits[0]);
      end
    end
  endtask

  initial begin
    errors     = 0;
    checks     = 0;
    lfsr_state = 16'd30;
    pc_counter = 32'h0000_1000;
    reset      = 1'b1;
    req        = make_req(1'b0, 1'b0, lsu_pkg::size_word, 1'b0, 32'd0, 32'd0);
    req_pc     = 32'd0;
    pass_data  = 32'd0;
    flush      = 1'b0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    word_round_trip();
    sub_word_stores();
    load_extension();
    pass_through();
    flush_handling();
    random_accesses();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
